//--- Makefile
# Verilator flow for the tinker core, variables can be overridden

VERILATOR ?= verilator
TOP       ?= tinker_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --timing --assert --timescale 1ns/1ps

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

build:
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation reported failure"; exit 1; fi
	@if ! grep -q "Test passed" $(LOG); then echo "simulation ended without a result"; exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- all.f
+incdir+common
common/isa_pkg.sv
common/core_pkg.sv
common/ex_mem_if.sv
core/fetch_unit.sv
core/decode_stage.sv
core/execute_stage.sv
core/memory_writeback.sv
design/tinker_top.sv
test/tb_clock.sv
test/tinker_asserts.sv
test/tinker_tb.sv

//--- common/core_pkg.sv
`include "tinker_settings.svh"

package core_pkg;

    // ------------------------------------------------------------------
    // datapath types
    // ------------------------------------------------------------------

    // register and memory word
    typedef logic [`TINKER_XLEN-1:0] word_t;

    // byte address of an instruction
    typedef logic [`TINKER_XLEN-1:0] pc_t;

    // ------------------------------------------------------------------
    // memory address types
    // ------------------------------------------------------------------

    // word index, pc / 4
    typedef logic [$clog2(`TINKER_IMEM_WORDS)-1:0] imem_addr_t;

    // byte address, wraps at the memory size
    typedef logic [$clog2(`TINKER_DMEM_BYTES)-1:0] dmem_addr_t;

endpackage

//--- common/ex_mem_if.sv
`timescale 1ns/1ps

// execute to memory stage record, one register advancing every cycle
interface ex_mem_if;
    logic                 valid;
    logic                 reg_write;
    logic                 mem_read;
    logic                 mem_write;
    logic                 halt;
    isa_pkg::reg_idx_t    rd;
    core_pkg::word_t      result;
    core_pkg::dmem_addr_t addr;
    core_pkg::word_t      store_data;

    // execute owns the record and reads it back for forwarding
    modport exec (
        output valid, reg_write, mem_read, mem_write, halt,
        output rd, result, addr, store_data
    );

    // memory stage consumes it
    modport mem (
        input valid, reg_write, mem_read, mem_write, halt,
        input rd, result, addr, store_data
    );
endinterface

//--- common/isa_pkg.sv
package isa_pkg;

    // ------------------------------------------------------------------
    // instruction word layout
    // ------------------------------------------------------------------

    // lsb of each field, widths follow from the types below
    localparam int OP_LSB = 27;
    localparam int RD_LSB = 22;
    localparam int RS_LSB = 17;
    localparam int RT_LSB = 12;
    localparam int L_LSB  = 0;

    typedef logic [31:0] instr_t;
    typedef logic [4:0]  reg_idx_t;
    typedef logic [11:0] imm_t;

    // ------------------------------------------------------------------
    // opcodes
    // ------------------------------------------------------------------
    typedef enum logic [4:0] {
        // logic
        OP_AND   = 5'h00,
        OP_OR    = 5'h01,
        OP_XOR   = 5'h02,
        OP_NOT   = 5'h03,
        // shifts, register then literal form
        OP_SHR   = 5'h04,
        OP_SHRI  = 5'h05,
        OP_SHL   = 5'h06,
        OP_SHLI  = 5'h07,
        // control flow
        OP_JMP   = 5'h08,
        OP_JMPL  = 5'h0a,
        OP_BRNZ  = 5'h0b,
        OP_BRGT  = 5'h0e,
        OP_HALT  = 5'h0f,
        // data movement
        OP_LOAD  = 5'h10,
        OP_MOV   = 5'h11,
        OP_MOVI  = 5'h12,
        OP_STORE = 5'h13,
        // arithmetic
        OP_ADD   = 5'h18,
        OP_ADDI  = 5'h19,
        OP_SUB   = 5'h1a,
        OP_SUBI  = 5'h1b
    } opcode_e;

endpackage

//--- common/tinker_settings.svh
`ifndef TINKER_SETTINGS_SVH
`define TINKER_SETTINGS_SVH

// ----------------------------------------------------------------------
// core sizing
// ----------------------------------------------------------------------

// datapath width in bits
`define TINKER_XLEN 64

// register file entries, r0 hardwired to zero
`define TINKER_NUM_REGS 32

// ----------------------------------------------------------------------
// memories and fetch
// ----------------------------------------------------------------------

// instruction memory depth in 32-bit words
`define TINKER_IMEM_WORDS 256

// data memory size in bytes, addresses wrap
`define TINKER_DMEM_BYTES 4096

// first fetch address out of reset
`define TINKER_RESET_PC 0

`endif

//--- core/decode_stage.sv
`timescale 1ns/1ps
`include "tinker_settings.svh"

module decode_stage (
    input  logic              clk,
    input  logic              reset,
    input  isa_pkg::instr_t   instr,
    input  core_pkg::pc_t     instr_pc,
    input  logic              instr_valid,
    input  logic              redirect,
    input  logic              wb_en,
    input  isa_pkg::reg_idx_t wb_rd,
    input  core_pkg::word_t   wb_data,
    output logic              stall,
    output core_pkg::pc_t     id_ex_pc,
    output isa_pkg::opcode_e  id_ex_op,
    output isa_pkg::reg_idx_t id_ex_rd,
    output isa_pkg::reg_idx_t id_ex_rs,
    output isa_pkg::reg_idx_t id_ex_rt,
    output isa_pkg::imm_t     id_ex_l,
    output core_pkg::word_t   id_ex_a,
    output core_pkg::word_t   id_ex_b,
    output core_pkg::word_t   id_ex_rd_val,
    output logic              id_ex_valid,
    output logic              id_ex_load
);
    core_pkg::word_t   regs [`TINKER_NUM_REGS];
    isa_pkg::opcode_e  op;
    isa_pkg::reg_idx_t rd;
    isa_pkg::reg_idx_t rs;
    isa_pkg::reg_idx_t rt;
    isa_pkg::imm_t     l;
    logic              uses_rs;
    logic              uses_rt;
    logic              uses_rd;
    logic              hazard;
    core_pkg::word_t   rs_val;
    core_pkg::word_t   rt_val;
    core_pkg::word_t   rd_val;

    // ------------------------------------------------------------------
    // field split
    // ------------------------------------------------------------------
    assign op = isa_pkg::opcode_e'(instr[isa_pkg::OP_LSB +: 5]);
    assign rd = instr[isa_pkg::RD_LSB +: $bits(isa_pkg::reg_idx_t)];
    assign rs = instr[isa_pkg::RS_LSB +: $bits(isa_pkg::reg_idx_t)];
    assign rt = instr[isa_pkg::RT_LSB +: $bits(isa_pkg::reg_idx_t)];
    assign l  = instr[isa_pkg::L_LSB +: $bits(isa_pkg::imm_t)];

    // which fields are real sources
    always_comb begin
        uses_rs = 1'b1;
        uses_rt = 1'b0;
        uses_rd = 1'b0;
        case (op)
            isa_pkg::OP_ADD, isa_pkg::OP_SUB, isa_pkg::OP_AND, isa_pkg::OP_OR,
            isa_pkg::OP_XOR, isa_pkg::OP_SHR, isa_pkg::OP_SHL: begin
                uses_rt = 1'b1;
            end
            isa_pkg::OP_BRGT: begin
                uses_rt = 1'b1;
                uses_rd = 1'b1;
            end
            // rd is the target or the store base
            isa_pkg::OP_BRNZ, isa_pkg::OP_STORE: begin
                uses_rd = 1'b1;
            end
            isa_pkg::OP_JMP: begin
                uses_rs = 1'b0;
                uses_rd = 1'b1;
            end
            isa_pkg::OP_JMPL, isa_pkg::OP_MOVI, isa_pkg::OP_HALT: begin
                uses_rs = 1'b0;
            end
            default: begin
                uses_rs = 1'b1;
            end
        endcase
    end

    // ------------------------------------------------------------------
    // register file
    // ------------------------------------------------------------------

    // r0 reads zero, same-cycle writeback bypassed
    function automatic core_pkg::word_t read_reg(input isa_pkg::reg_idx_t idx);
        if (idx == '0) begin
            return '0;
        end
        if (wb_en && wb_rd == idx) begin
            return wb_data;
        end
        return regs[idx];
    endfunction

    always_comb begin
        rs_val = read_reg(rs);
        rt_val = read_reg(rt);
        rd_val = read_reg(rd);
    end

    // wb_en never carries r0
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wb_en) begin
            regs[wb_rd] <= wb_data;
        end
    end

    // ------------------------------------------------------------------
    // load-use interlock
    // ------------------------------------------------------------------
    assign hazard = instr_valid & id_ex_valid & id_ex_load & (id_ex_rd != '0) &
                    ((uses_rs & (rs == id_ex_rd)) |
                     (uses_rt & (rt == id_ex_rd)) |
                     (uses_rd & (rd == id_ex_rd)));
    assign stall  = hazard;

    // ------------------------------------------------------------------
    // ID/EX register
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            id_ex_valid <= 1'b0;
            id_ex_load  <= 1'b0;
        end else begin
            // bubble on interlock or flush
            id_ex_valid <= instr_valid & ~hazard & ~redirect;
            id_ex_load  <= instr_valid & ~hazard & ~redirect & (op == isa_pkg::OP_LOAD);
        end
    end

    // literal form gets rt = r0 so execute never forwards over it
    always_ff @(posedge clk) begin
        id_ex_pc     <= instr_pc;
        id_ex_op     <= op;
        id_ex_rd     <= rd;
        id_ex_rs     <= rs;
        id_ex_rt     <= uses_rt ? rt : '0;
        id_ex_l      <= l;
        id_ex_a      <= rs_val;
        id_ex_b      <= uses_rt ? rt_val : core_pkg::word_t'(l);
        id_ex_rd_val <= rd_val;
    end
endmodule

//--- core/execute_stage.sv
`timescale 1ns/1ps

module execute_stage (
    input  logic              clk,
    input  logic              reset,
    input  core_pkg::pc_t     id_ex_pc,
    input  isa_pkg::opcode_e  id_ex_op,
    input  isa_pkg::reg_idx_t id_ex_rd,
    input  isa_pkg::reg_idx_t id_ex_rs,
    input  isa_pkg::reg_idx_t id_ex_rt,
    input  isa_pkg::imm_t     id_ex_l,
    input  core_pkg::word_t   id_ex_a,
    input  core_pkg::word_t   id_ex_b,
    input  core_pkg::word_t   id_ex_rd_val,
    input  logic              id_ex_valid,
    input  logic              id_ex_load,
    input  logic              wb_en,
    input  isa_pkg::reg_idx_t wb_rd,
    input  core_pkg::word_t   wb_data,
    ex_mem_if.exec            em,
    output logic              redirect,
    output core_pkg::pc_t     target
);
    logic            ex_fwd;
    core_pkg::word_t a_f;
    core_pkg::word_t b_f;
    core_pkg::word_t rd_f;
    core_pkg::word_t lit;
    core_pkg::word_t alu_res;
    core_pkg::word_t mem_base;
    logic            writes;
    logic            taken;

    // ------------------------------------------------------------------
    // forwarding
    // ------------------------------------------------------------------

    // load data is not in EX/MEM yet, the interlock covers it
    assign ex_fwd = em.valid & em.reg_write & ~em.mem_read;

    // EX/MEM first, then writeback, then the decoded value
    function automatic core_pkg::word_t fwd(input isa_pkg::reg_idx_t src,
                                            input core_pkg::word_t   val);
        if (src == '0) begin
            return val;
        end
        if (ex_fwd && em.rd == src) begin
            return em.result;
        end
        if (wb_en && wb_rd == src) begin
            return wb_data;
        end
        return val;
    endfunction

    always_comb begin
        a_f  = fwd(id_ex_rs, id_ex_a);
        b_f  = fwd(id_ex_rt, id_ex_b);
        rd_f = fwd(id_ex_rd, id_ex_rd_val);
    end

    // ------------------------------------------------------------------
    // ALU and branch decision
    // ------------------------------------------------------------------
    assign lit = core_pkg::word_t'(id_ex_l);

    always_comb begin
        alu_res = '0;
        writes  = 1'b1;
        taken   = 1'b0;
        case (id_ex_op)
            // b already holds rt or the literal
            isa_pkg::OP_ADD, isa_pkg::OP_ADDI: alu_res = a_f + b_f;
            isa_pkg::OP_SUB, isa_pkg::OP_SUBI: alu_res = a_f - b_f;
            isa_pkg::OP_AND: alu_res = a_f & b_f;
            isa_pkg::OP_OR:  alu_res = a_f | b_f;
            isa_pkg::OP_XOR: alu_res = a_f ^ b_f;
            isa_pkg::OP_NOT: alu_res = ~a_f;
            isa_pkg::OP_SHR, isa_pkg::OP_SHRI: alu_res = a_f >> b_f;
            isa_pkg::OP_SHL, isa_pkg::OP_SHLI: alu_res = a_f << b_f;
            isa_pkg::OP_MOV:  alu_res = a_f;
            isa_pkg::OP_MOVI: alu_res = lit;
            // result replaced by memory data later
            isa_pkg::OP_LOAD: alu_res = '0;
            isa_pkg::OP_JMP, isa_pkg::OP_JMPL: begin
                writes = 1'b0;
                taken  = 1'b1;
            end
            isa_pkg::OP_BRNZ: begin
                writes = 1'b0;
                taken  = (a_f != '0);
            end
            isa_pkg::OP_BRGT: begin
                writes = 1'b0;
                taken  = ($signed(a_f) > $signed(b_f));
            end
            default: writes = 1'b0;
        endcase
    end

    // only pc+L is relative, the rest jump to rd
    assign target   = (id_ex_op == isa_pkg::OP_JMPL) ? id_ex_pc + lit : rd_f;
    assign redirect = id_ex_valid & taken;

    // store base is rd, load base is rs
    assign mem_base = (id_ex_op == isa_pkg::OP_STORE) ? rd_f : a_f;

    // ------------------------------------------------------------------
    // EX/MEM record
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            em.valid     <= 1'b0;
            em.reg_write <= 1'b0;
            em.mem_read  <= 1'b0;
            em.mem_write <= 1'b0;
            em.halt      <= 1'b0;
        end else begin
            em.valid     <= id_ex_valid;
            em.reg_write <= writes;
            em.mem_read  <= id_ex_load;
            em.mem_write <= (id_ex_op == isa_pkg::OP_STORE);
            em.halt      <= (id_ex_op == isa_pkg::OP_HALT);
        end
    end

    always_ff @(posedge clk) begin
        em.rd         <= id_ex_rd;
        em.result     <= alu_res;
        em.addr       <= core_pkg::dmem_addr_t'(mem_base + lit);
        em.store_data <= a_f;
    end
endmodule

//--- core/fetch_unit.sv
`timescale 1ns/1ps
`include "tinker_settings.svh"

module fetch_unit (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 stall,
    input  logic                 redirect,
    input  core_pkg::pc_t        target,
    input  logic                 prog_we,
    input  core_pkg::imem_addr_t prog_addr,
    input  isa_pkg::instr_t      prog_data,
    output isa_pkg::instr_t      instr,
    output core_pkg::pc_t        instr_pc,
    output logic                 instr_valid
);
    // program store, written through the load port while idle
    isa_pkg::instr_t      imem [`TINKER_IMEM_WORDS];
    core_pkg::pc_t        pc;
    core_pkg::imem_addr_t fetch_idx;
    logic                 advance;

    // word index, byte offset bits dropped
    assign fetch_idx = pc[2 +: $bits(core_pkg::imem_addr_t)];
    assign advance   = run & ~stall & ~redirect;

    always_ff @(posedge clk) begin
        if (prog_we) begin
            imem[prog_addr] <= prog_data;
        end
    end

    // ------------------------------------------------------------------
    // pc and IF/ID valid
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            pc          <= core_pkg::pc_t'(`TINKER_RESET_PC);
            instr_valid <= 1'b0;
        end else if (redirect) begin
            // taken branch, squash the slot behind it
            pc          <= target;
            instr_valid <= 1'b0;
        end else if (!stall) begin
            // idle core holds pc and feeds bubbles
            if (run) begin
                pc <= pc + 4;
            end
            instr_valid <= run;
        end
    end

    // IF/ID payload
    always_ff @(posedge clk) begin
        if (advance) begin
            instr    <= imem[fetch_idx];
            instr_pc <= pc;
        end
    end
endmodule

//--- core/memory_writeback.sv
`timescale 1ns/1ps
`include "tinker_settings.svh"

module memory_writeback (
    input  logic              clk,
    input  logic              reset,
    ex_mem_if.mem             em,
    output logic              wb_en,
    output isa_pkg::reg_idx_t wb_rd,
    output core_pkg::word_t   wb_data,
    output logic              hlt
);
    localparam int WORD_BYTES = `TINKER_XLEN / 8;

    logic [7:0]      dmem [`TINKER_DMEM_BYTES];
    core_pkg::word_t load_data;
    logic            store_en;
    logic            mw_reg_write;
    logic            mw_halt;

    // ------------------------------------------------------------------
    // data memory, little endian, byte addresses wrap
    // ------------------------------------------------------------------
    always_comb begin
        for (int i = 0; i < WORD_BYTES; i++) begin
            load_data[8*i +: 8] = dmem[em.addr + core_pkg::dmem_addr_t'(i)];
        end
    end

    // no stores once a halt has reached writeback
    assign store_en = em.valid & em.mem_write & ~mw_halt & ~hlt;

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            for (int i = 0; i < `TINKER_DMEM_BYTES; i++) begin
                dmem[i] <= '0;
            end
        end else if (store_en) begin
            for (int i = 0; i < WORD_BYTES; i++) begin
                dmem[em.addr + core_pkg::dmem_addr_t'(i)] <= em.store_data[8*i +: 8];
            end
        end
    end

    // ------------------------------------------------------------------
    // MEM/WB register and sticky halt
    // ------------------------------------------------------------------
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            mw_reg_write <= 1'b0;
            mw_halt      <= 1'b0;
            hlt          <= 1'b0;
        end else begin
            mw_reg_write <= em.valid & em.reg_write;
            mw_halt      <= em.valid & em.halt;
            // stays set until reset
            if (mw_halt) begin
                hlt <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        wb_rd   <= em.rd;
        wb_data <= em.mem_read ? load_data : em.result;
    end

    // r0 writes dropped, nothing retires after halt
    assign wb_en = mw_reg_write & (wb_rd != '0) & ~hlt;
endmodule

//--- design/tinker_top.sv
`timescale 1ns/1ps

module tinker_top (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 run,
    input  logic                 prog_we,
    input  core_pkg::imem_addr_t prog_addr,
    input  isa_pkg::instr_t      prog_data,
    output logic                 hlt,
    output logic                 wb_valid,
    output isa_pkg::reg_idx_t    wb_rd,
    output core_pkg::word_t      wb_data
);
    // fetch to decode
    isa_pkg::instr_t   instr;
    core_pkg::pc_t     instr_pc;
    logic              instr_valid;
    logic              stall;

    // execute to fetch and decode
    logic              redirect;
    core_pkg::pc_t     target;

    // ID/EX register
    core_pkg::pc_t     id_ex_pc;
    isa_pkg::opcode_e  id_ex_op;
    isa_pkg::reg_idx_t id_ex_rd;
    isa_pkg::reg_idx_t id_ex_rs;
    isa_pkg::reg_idx_t id_ex_rt;
    isa_pkg::imm_t     id_ex_l;
    core_pkg::word_t   id_ex_a;
    core_pkg::word_t   id_ex_b;
    core_pkg::word_t   id_ex_rd_val;
    logic              id_ex_valid;
    logic              id_ex_load;

    ex_mem_if em ();

    fetch_unit i_fetch (
        .clk, .reset, .run, .stall, .redirect, .target,
        .prog_we, .prog_addr, .prog_data,
        .instr, .instr_pc, .instr_valid
    );

    // writeback bus doubles as the retire port
    decode_stage i_decode (
        .clk, .reset, .instr, .instr_pc, .instr_valid, .redirect,
        .wb_en(wb_valid), .wb_rd, .wb_data, .stall,
        .id_ex_pc, .id_ex_op, .id_ex_rd, .id_ex_rs, .id_ex_rt, .id_ex_l,
        .id_ex_a, .id_ex_b, .id_ex_rd_val, .id_ex_valid, .id_ex_load
    );

    execute_stage i_execute (
        .clk, .reset,
        .id_ex_pc, .id_ex_op, .id_ex_rd, .id_ex_rs, .id_ex_rt, .id_ex_l,
        .id_ex_a, .id_ex_b, .id_ex_rd_val, .id_ex_valid, .id_ex_load,
        .wb_en(wb_valid), .wb_rd, .wb_data,
        .em(em.exec), .redirect, .target
    );

    memory_writeback i_mem_wb (
        .clk, .reset, .em(em.mem),
        .wb_en(wb_valid), .wb_rd, .wb_data, .hlt
    );
endmodule

//--- test/tb_clock.sv
`timescale 1ns/1ps

// free running clock for the testbench
module tb_clock #(
    parameter int PERIOD_NS = 100
) (
    output logic clk
);
    // starts low, first rising edge half a period in
    initial begin
        clk = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk = ~clk;
        end
    end
endmodule

//--- test/tinker_asserts.sv
`timescale 1ns/1ps

// checks bound onto the core top level
module tinker_asserts (
    input logic              clk,
    input logic              reset,
    input logic              run,
    input logic              prog_we,
    input logic              hlt,
    input logic              wb_valid,
    input isa_pkg::reg_idx_t wb_rd
);
    // ----------------------------------------------------------------------
    // halt and retire port
    // ----------------------------------------------------------------------

    // halt is sticky until the next reset
    hlt_sticky: assert property (@(posedge clk) disable iff (reset) !$fell(hlt))
        else $error("hlt fell while reset was low");

    // r0 writes never show on the retire port
    no_r0_retire: assert property (@(posedge clk) disable iff (reset) wb_valid |-> wb_rd != '0)
        else $error("retirement reported for r0");

    // ----------------------------------------------------------------------
    // program load port
    // ----------------------------------------------------------------------

    // loading only while the core is idle
    load_while_idle: assert property (@(posedge clk) disable iff (reset) run |-> !prog_we)
        else $error("prog_we high while run is high");
endmodule

//--- test/tinker_tb.sv
`timescale 1ns/1ps
`include "tinker_settings.svh"

module tinker_tb;
    localparam int          RESET_CYCLES = 16;
    localparam int          RUN_TIMEOUT  = 2000;
    localparam int          QUIET_CYCLES = 20;
    localparam logic [31:0] SEED         = 32'h1dbb_aff2;

    logic                 clk;
    logic                 reset;
    logic                 run;
    logic                 prog_we;
    core_pkg::imem_addr_t prog_addr;
    isa_pkg::instr_t      prog_data;
    logic                 hlt;
    logic                 wb_valid;
    isa_pkg::reg_idx_t    wb_rd;
    core_pkg::word_t      wb_data;

    // program image and the retirements it must produce, in order
    isa_pkg::instr_t   prog [$];
    isa_pkg::reg_idx_t exp_rd [$];
    core_pkg::word_t   exp_data [$];
    int                errors;
    int                retired;
    int                cycles;

    tb_clock #(.PERIOD_NS(100)) i_clock (.clk(clk));

    tinker_top i_tinker_top (
        .clk(clk), .reset(reset), .run(run),
        .prog_we(prog_we), .prog_addr(prog_addr), .prog_data(prog_data),
        .hlt(hlt), .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_data(wb_data)
    );

    bind tinker_top tinker_asserts i_asserts (
        .clk(clk), .reset(reset), .run(run), .prog_we(prog_we),
        .hlt(hlt), .wb_valid(wb_valid), .wb_rd(wb_rd)
    );

    // ----------------------------------------------------------------------
    // program table
    // ----------------------------------------------------------------------

    // opcode 31:27, rd 26:22, rs 21:17, rt 16:12, literal 11:0
    function automatic isa_pkg::instr_t encode(isa_pkg::opcode_e op, int rd, int rs,
                                               int rt, int l);
        return {op, isa_pkg::reg_idx_t'(rd), isa_pkg::reg_idx_t'(rs),
                isa_pkg::reg_idx_t'(rt), isa_pkg::imm_t'(l)};
    endfunction

    // instruction that must retire rd with data
    task automatic retire(isa_pkg::instr_t instr, int rd, core_pkg::word_t data);
        prog.push_back(instr);
        exp_rd.push_back(isa_pkg::reg_idx_t'(rd));
        exp_data.push_back(data);
    endtask

    // no retirement expected
    task automatic silent(isa_pkg::instr_t instr);
        prog.push_back(instr);
    endtask

    task automatic build_program();
        int              lit_a;
        int              lit_b;
        core_pkg::word_t va;
        core_pkg::word_t vb;
        // nonzero literals so brnz on them is taken
        lit_a = int'($urandom % 32'd4095) + 1;
        lit_b = int'($urandom % 32'd4095) + 1;
        va    = core_pkg::word_t'(lit_a);
        vb    = core_pkg::word_t'(lit_b);
        retire(encode(isa_pkg::OP_MOVI, 1, 0, 0, lit_a), 1, va);
        retire(encode(isa_pkg::OP_MOVI, 2, 0, 0, lit_b), 2, vb);
        // back to back dependencies, EX/MEM and writeback forwarding
        retire(encode(isa_pkg::OP_ADD, 3, 1, 2, 0), 3, va + vb);
        retire(encode(isa_pkg::OP_SUB, 4, 3, 1, 0), 4, vb);
        retire(encode(isa_pkg::OP_AND, 5, 3, 2, 0), 5, (va + vb) & vb);
        retire(encode(isa_pkg::OP_OR, 6, 1, 2, 0), 6, va | vb);
        retire(encode(isa_pkg::OP_XOR, 7, 6, 5, 0), 7, (va | vb) ^ ((va + vb) & vb));
        retire(encode(isa_pkg::OP_NOT, 8, 1, 0, 0), 8, ~va);
        // literal forms, source is the destination itself
        retire(encode(isa_pkg::OP_ADDI, 3, 3, 0, 'h0ff), 3, va + vb + 64'h0ff);
        retire(encode(isa_pkg::OP_SUBI, 4, 4, 0, 1), 4, vb - 64'd1);
        retire(encode(isa_pkg::OP_MOVI, 10, 0, 0, 3), 10, 64'd3);
        retire(encode(isa_pkg::OP_SHL, 11, 1, 10, 0), 11, va << 3);
        retire(encode(isa_pkg::OP_SHR, 12, 11, 10, 0), 12, va);
        retire(encode(isa_pkg::OP_SHLI, 1, 1, 0, 4), 1, va << 4);
        retire(encode(isa_pkg::OP_SHRI, 1, 1, 0, 2), 1, va << 2);
        retire(encode(isa_pkg::OP_MOV, 14, 1, 0, 0), 14, va << 2);
        // r0 write is dropped and r0 still reads zero
        silent(encode(isa_pkg::OP_MOVI, 0, 0, 0, 'h5a5));
        retire(encode(isa_pkg::OP_ADD, 15, 0, 1, 0), 15, va << 2);
        // store then load, then a load-use consumer
        retire(encode(isa_pkg::OP_MOVI, 16, 0, 0, 'h100), 16, 64'h100);
        silent(encode(isa_pkg::OP_STORE, 16, 3, 0, 8));
        retire(encode(isa_pkg::OP_LOAD, 17, 16, 0, 8), 17, va + vb + 64'h0ff);
        retire(encode(isa_pkg::OP_ADD, 18, 17, 2, 0), 18, va + vb + vb + 64'h0ff);
        silent(encode(isa_pkg::OP_STORE, 16, 8, 0, 16));
        retire(encode(isa_pkg::OP_LOAD, 19, 16, 0, 16), 19, ~va);
        retire(encode(isa_pkg::OP_NOT, 20, 19, 0, 0), 20, va);
        // word 25, pc+12 lands on word 28
        silent(encode(isa_pkg::OP_JMPL, 0, 0, 0, 12));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h111));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h222));
        // jump to rd, word 32
        retire(encode(isa_pkg::OP_MOVI, 22, 0, 0, 'h080), 22, 64'h080);
        silent(encode(isa_pkg::OP_JMP, 22, 0, 0, 0));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h333));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h444));
        // brnz taken to word 36, then one on r0 falls through
        retire(encode(isa_pkg::OP_MOVI, 23, 0, 0, 'h090), 23, 64'h090);
        silent(encode(isa_pkg::OP_BRNZ, 23, 1, 0, 0));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h555));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h666));
        silent(encode(isa_pkg::OP_BRNZ, 23, 0, 0, 0));
        // top literal bit set, upper bits stay zero
        retire(encode(isa_pkg::OP_MOVI, 24, 0, 0, 'hf77), 24, 64'hf77);
        // signed compare, b > ~a is taken to word 42, reverse is not
        retire(encode(isa_pkg::OP_MOVI, 25, 0, 0, 'h0a8), 25, 64'h0a8);
        silent(encode(isa_pkg::OP_BRGT, 25, 2, 8, 0));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h888));
        silent(encode(isa_pkg::OP_MOVI, 21, 0, 0, 'h999));
        silent(encode(isa_pkg::OP_BRGT, 25, 8, 2, 0));
        // r21 only ever written by flushed slots
        retire(encode(isa_pkg::OP_MOV, 26, 21, 0, 0), 26, 64'd0);
        silent(encode(isa_pkg::OP_HALT, 0, 0, 0, 0));
    endtask

    // ----------------------------------------------------------------------
    // load and retire checks
    // ----------------------------------------------------------------------

    // whole memory written, unused words are halts tagged with their address
    task automatic load_program();
        for (int i = 0; i < `TINKER_IMEM_WORDS; i++) begin
            @(negedge clk);
            prog_we   = 1'b1;
            prog_addr = core_pkg::imem_addr_t'(i);
            prog_data = (i < prog.size()) ? prog[i] : encode(isa_pkg::OP_HALT, 0, 0, 0, i);
        end
        @(negedge clk);
        prog_we = 1'b0;
    endtask

    task automatic check_retire();
        if (retired >= exp_rd.size()) begin
            $display("error: wb_rd = %h wb_data = %h retired beyond the expected list",
                     wb_rd, wb_data);
            errors++;
        end else begin
            if (wb_rd !== exp_rd[retired]) begin
                $display("error: wb_rd = %h, expected %h at retirement %0d",
                         wb_rd, exp_rd[retired], retired);
                errors++;
            end
            if (wb_data !== exp_data[retired]) begin
                $display("error: wb_data = %h, expected %h at retirement %0d",
                         wb_data, exp_data[retired], retired);
                errors++;
            end
        end
        retired++;
    endtask

    // ----------------------------------------------------------------------
    // main flow
    // ----------------------------------------------------------------------
    initial begin
        reset     = 1'b1;
        run       = 1'b0;
        prog_we   = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        errors    = 0;
        retired   = 0;
        void'($urandom(SEED));
        build_program();

        repeat (RESET_CYCLES) @(negedge clk);
        reset = 1'b0;
        @(negedge clk);
        if (hlt !== 1'b0) begin
            $display("error: hlt = %h after reset, expected 0", hlt);
            errors++;
        end
        if (wb_valid !== 1'b0) begin
            $display("error: wb_valid = %h after reset, expected 0", wb_valid);
            errors++;
        end

        load_program();
        run = 1'b1;

        // retirements in order until halt
        cycles = 0;
        while (hlt !== 1'b1 && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
            if (wb_valid === 1'b1) begin
                check_retire();
            end
        end

        if (hlt !== 1'b1) begin
            $display("timeout: hlt did not rise within %0d cycles of run", RUN_TIMEOUT);
            errors++;
        end else begin
            // core stays quiet once halted
            for (int i = 0; i < QUIET_CYCLES; i++) begin
                @(negedge clk);
                if (wb_valid !== 1'b0) begin
                    $display("error: wb_valid = %h after hlt, expected 0", wb_valid);
                    errors++;
                end
                if (hlt !== 1'b1) begin
                    $display("error: hlt = %h after it had risen, expected 1", hlt);
                    errors++;
                end
            end
        end
        if (retired != exp_rd.size()) begin
            $display("only %0d of %0d expected retirements were seen", retired, exp_rd.size());
            errors++;
        end

        $display("retired %0d of %0d expected, %0d errors", retired, exp_rd.size(), errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule
